/* src/cpu_macros.svh */
/*
 * cpu macros
 * widths, DRAM placement and cache window geometry for the
 * multi-cycle 16-bit processor
 */
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// datapath widths
`define CPU_WORD_W        16
`define CPU_PTR_W         12
`define CPU_AXI_ADDR_W    32

// every byte pointer sits at this offset on the bus
`define CPU_DRAM_BASE     32'h0000_1000

// cache window, also the read burst length in beats
`define CPU_WIN_WORDS     128
`define CPU_WIN_BYTES     256
`define CPU_WIN_MAX_BASE  3840
`define CPU_LINE_IDX_W    7

`endif

/* src/cpu_pkg.sv */
/*
 * cpu package
 * shared data types, instruction opcodes and core FSM states
 */
`include "cpu_macros.svh"

package cpu_pkg;

  // register and memory word, signed
  typedef logic signed [`CPU_WORD_W-1:0] word_t;

  // byte pointer into the 4 KB space
  typedef logic [`CPU_PTR_W-1:0] ptr_t;

  typedef logic [3:0] reg_idx_t;

  // opcodes 3'b110 and 3'b111 are unused
  typedef enum logic [2:0] {
    OP_ARITH  = 3'b000,
    OP_CMPMUL = 3'b001,
    OP_LW     = 3'b010,
    OP_SW     = 3'b011,
    OP_BEQ    = 3'b100,
    OP_J      = 3'b101
  } opcode_e;

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_FETCH,
    ST_DECODE,
    ST_EXE,
    ST_LOAD,
    ST_STORE,
    ST_WB
  } core_state_e;

endpackage

/* src/cpu_ifs.sv */
/*
 * internal links of the processor
 * core to instruction cache, core to data cache, and each
 * cache to the shared DRAM read arbiter
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

// instruction fetch, fetch is a level, inst_valid a pulse
interface imem_if;
  logic                   fetch;
  logic [`CPU_PTR_W-1:0]  pc;
  logic [`CPU_WORD_W-1:0] inst;
  logic                   inst_valid;

  modport core  (output fetch, pc, input inst, inst_valid);
  modport cache (input fetch, pc, output inst, inst_valid);
endinterface

// load/store, requests held until done
interface dmem_if;
  logic                   ld_req;
  logic                   st_req;
  logic [`CPU_PTR_W-1:0]  addr;
  logic [`CPU_WORD_W-1:0] wdata;
  logic [`CPU_WORD_W-1:0] rdata;
  logic                   done;

  modport core  (output ld_req, st_req, addr, wdata, input rdata, done);
  modport cache (input ld_req, st_req, addr, wdata, output rdata, done);
endinterface

// window refill, one per cache
interface rd_port_if;
  logic                   req;
  logic [`CPU_PTR_W-1:0]  base;
  logic                   beat;
  logic [`CPU_WORD_W-1:0] data;
  logic                   last;

  modport requester (output req, base, input beat, data, last);
  modport arbiter   (input req, base, output beat, data, last);
endinterface

/* src/read_arbiter.sv */
/*
 * read arbiter
 * owns the single DRAM read channel and hands whole 128-beat
 * bursts to the instruction or data cache, instruction first
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module read_arbiter (
  input  logic                       clk,
  input  logic                       rst_n,
  rd_port_if.arbiter                 inst_port,
  rd_port_if.arbiter                 data_port,
  output logic [`CPU_AXI_ADDR_W-1:0] araddr,
  output logic                       arvalid,
  input  logic                       arready,
  input  cpu_pkg::word_t             rdata,
  input  logic                       rvalid,
  input  logic                       rlast,
  output logic                       rready
);

  typedef enum logic {ARB_ADDR, ARB_DATA} arb_state_e;

  arb_state_e            state_q;
  logic                  gnt_data_q;
  logic                  req_any;
  logic                  issue;
  logic [`CPU_PTR_W-1:0] sel_base;

  assign req_any  = inst_port.req | data_port.req;
  assign sel_base = inst_port.req ? inst_port.base : data_port.base;
  // new burst only when no address is on the bus yet
  assign issue    = (state_q == ARB_ADDR) && !arvalid && req_any;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= ARB_ADDR;
      arvalid    <= 1'b0;
      gnt_data_q <= 1'b0;
    end else begin
      case (state_q)
        ARB_ADDR: begin
          if (issue) begin
            arvalid    <= 1'b1;
            gnt_data_q <= !inst_port.req;
          end else if (arvalid && arready) begin
            arvalid <= 1'b0;
            state_q <= ARB_DATA;
          end
        end
        default: begin
          // grant released with the last beat
          if (rvalid && rlast) begin
            state_q <= ARB_ADDR;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      araddr <= `CPU_DRAM_BASE + {{(`CPU_AXI_ADDR_W-`CPU_PTR_W){1'b0}}, sel_base};
    end
  end

  assign rready = (state_q == ARB_DATA);

  // route beats to the granted cache
  assign inst_port.beat = rready && rvalid && !gnt_data_q;
  assign data_port.beat = rready && rvalid && gnt_data_q;
  assign inst_port.data = rdata;
  assign data_port.data = rdata;
  assign inst_port.last = rlast;
  assign data_port.last = rlast;

endmodule

/* src/inst_cache.sv */
/*
 * instruction cache
 * one 256-byte window of program words, refilled by a full
 * burst on a miss, single-cycle read on a hit
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module inst_cache (
  input  logic         clk,
  input  logic         rst_n,
  imem_if.cache        core,
  rd_port_if.requester bus
);
  import cpu_pkg::*;

  word_t                      mem [`CPU_WIN_WORDS];
  word_t                      inst_q;
  ptr_t                       base_q;
  ptr_t                       win_start;
  ptr_t                       offset;
  logic                       valid_q;
  logic                       req_q;
  logic                       inst_valid_q;
  logic                       hit;
  logic                       lookup;
  logic [`CPU_LINE_IDX_W-1:0] fill_idx_q;

  // window may not run past the end of the space
  assign win_start = (core.pc > ptr_t'(`CPU_WIN_MAX_BASE)) ?
                     ptr_t'(`CPU_WIN_MAX_BASE) : core.pc;
  assign offset    = core.pc - base_q;
  assign hit       = valid_q && (core.pc >= base_q) && (offset < ptr_t'(`CPU_WIN_BYTES));
  assign lookup    = !req_q && core.fetch && !inst_valid_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q      <= 1'b0;
      req_q        <= 1'b0;
      inst_valid_q <= 1'b0;
      base_q       <= '0;
      fill_idx_q   <= '0;
    end else begin
      inst_valid_q <= 1'b0;
      if (req_q) begin
        if (bus.beat) begin
          fill_idx_q <= fill_idx_q + 1'b1;
          if (bus.last) begin
            req_q   <= 1'b0;
            valid_q <= 1'b1;
          end
        end
      end else if (lookup) begin
        if (hit) begin
          inst_valid_q <= 1'b1;
        end else begin
          req_q      <= 1'b1;
          valid_q    <= 1'b0;
          base_q     <= {win_start[`CPU_PTR_W-1:1], 1'b0};
          fill_idx_q <= '0;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (bus.beat) begin
      mem[fill_idx_q] <= bus.data;
    end
    if (lookup && hit) begin
      inst_q <= mem[offset[`CPU_LINE_IDX_W:1]];
    end
  end

  assign core.inst       = inst_q;
  assign core.inst_valid = inst_valid_q;
  assign bus.req         = req_q;
  assign bus.base        = base_q;

endmodule

/* src/data_cache.sv */
/*
 * data cache
 * 256-byte load window refilled by burst on a miss; every store
 * is written through to DRAM as a single-beat write and also
 * updates the window when it hits
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module data_cache (
  input  logic                       clk,
  input  logic                       rst_n,
  dmem_if.cache                      core,
  rd_port_if.requester               bus,
  output logic [`CPU_AXI_ADDR_W-1:0] awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output cpu_pkg::word_t             wdata,
  output logic                       wvalid,
  output logic                       wlast,
  input  logic                       wready,
  input  logic                       bvalid,
  output logic                       bready
);
  import cpu_pkg::*;

  typedef enum logic [2:0] {DC_IDLE, DC_FILL, DC_AW, DC_W, DC_B} dc_state_e;

  dc_state_e                  state_q;
  word_t                      mem [`CPU_WIN_WORDS];
  word_t                      rdata_q;
  ptr_t                       base_q;
  ptr_t                       win_start;
  ptr_t                       offset;
  logic                       valid_q;
  logic                       done_q;
  logic                       hit;
  logic                       rd_go;
  logic [`CPU_LINE_IDX_W-1:0] fill_idx_q;

  assign win_start = (core.addr > ptr_t'(`CPU_WIN_MAX_BASE)) ?
                     ptr_t'(`CPU_WIN_MAX_BASE) : core.addr;
  assign offset    = core.addr - base_q;
  assign hit       = valid_q && (core.addr >= base_q) && (offset < ptr_t'(`CPU_WIN_BYTES));
  assign rd_go     = (state_q == DC_IDLE) && core.ld_req && !done_q && hit;

  ////////////////////////////////////////
  // control

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q    <= DC_IDLE;
      valid_q    <= 1'b0;
      done_q     <= 1'b0;
      base_q     <= '0;
      fill_idx_q <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        DC_IDLE: begin
          // done_q blocks a second pass while the core drops its request
          if (core.ld_req && !done_q) begin
            if (hit) begin
              done_q <= 1'b1;
            end else begin
              state_q    <= DC_FILL;
              valid_q    <= 1'b0;
              base_q     <= {win_start[`CPU_PTR_W-1:1], 1'b0};
              fill_idx_q <= '0;
            end
          end else if (core.st_req && !done_q) begin
            state_q <= DC_AW;
          end
        end
        DC_FILL: begin
          if (bus.beat) begin
            fill_idx_q <= fill_idx_q + 1'b1;
            if (bus.last) begin
              valid_q <= 1'b1;
              state_q <= DC_IDLE;
            end
          end
        end
        DC_AW: if (awready) state_q <= DC_W;
        DC_W:  if (wready) state_q <= DC_B;
        DC_B: begin
          if (bvalid) begin
            done_q  <= 1'b1;
            state_q <= DC_IDLE;
          end
        end
        default: state_q <= DC_IDLE;
      endcase
    end
  end

  ////////////////////////////////////////
  // window array

  always_ff @(posedge clk) begin
    if (bus.beat) begin
      mem[fill_idx_q] <= bus.data;
    end else if (state_q == DC_B && bvalid && hit) begin
      mem[offset[`CPU_LINE_IDX_W:1]] <= core.wdata;
    end
    if (rd_go) begin
      rdata_q <= mem[offset[`CPU_LINE_IDX_W:1]];
    end
  end

  // single-beat write, operands held by the core until done
  assign awaddr  = `CPU_DRAM_BASE + {{(`CPU_AXI_ADDR_W-`CPU_PTR_W){1'b0}}, core.addr};
  assign awvalid = (state_q == DC_AW);
  assign wdata   = core.wdata;
  assign wvalid  = (state_q == DC_W);
  assign wlast   = (state_q == DC_W);
  assign bready  = (state_q == DC_B);

  assign bus.req    = (state_q == DC_FILL);
  assign bus.base   = base_q;
  assign core.rdata = rdata_q;
  assign core.done  = done_q;

endmodule

/* src/cpu_core.sv */
/*
 * cpu core
 * sixteen signed registers, decoder, ALU and program counter,
 * sequenced one instruction at a time by the control FSM
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_core (
  input  logic clk,
  input  logic rst_n,
  imem_if.core imem,
  dmem_if.core dmem,
  output logic io_stall
);
  import cpu_pkg::*;

  core_state_e       state_q;
  word_t             regs [16];
  ptr_t              pc_q;
  ptr_t              tgt_q;
  ptr_t              addr_q;
  ptr_t              imm_off;
  logic              fetch_q;
  opcode_e           op_q;
  reg_idx_t          rt_q;
  reg_idx_t          rd_q;
  logic              func_q;
  logic signed [4:0] imm_q;
  word_t             rs_val_q;
  word_t             rt_val_q;
  word_t             alu_res;
  word_t             res_q;
  word_t             mem_sum;

  // ########################################
  // control FSM and program counter
  // ########################################

  // branch offset in bytes, sign extended
  assign imm_off = {{6{imm_q[4]}}, imm_q, 1'b0};

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      fetch_q <= 1'b0;
      pc_q    <= '0;
    end else begin
      case (state_q)
        ST_IDLE: state_q <= ST_FETCH;
        ST_FETCH: begin
          fetch_q <= 1'b1;
          state_q <= ST_DECODE;
        end
        ST_DECODE: begin
          if (imem.inst_valid) begin
            fetch_q <= 1'b0;
            state_q <= ST_EXE;
          end
        end
        ST_EXE: begin
          case (op_q)
            OP_BEQ: begin
              if (rs_val_q == rt_val_q) begin
                pc_q <= pc_q + 12'd2 + imm_off;
              end else begin
                pc_q <= pc_q + 12'd2;
              end
            end
            OP_J:    pc_q <= tgt_q;
            default: pc_q <= pc_q + 12'd2;
          endcase
          case (op_q)
            OP_LW:   state_q <= ST_LOAD;
            OP_SW:   state_q <= ST_STORE;
            default: state_q <= ST_WB;
          endcase
        end
        ST_LOAD, ST_STORE: if (dmem.done) state_q <= ST_WB;
        default: state_q <= ST_FETCH;
      endcase
    end
  end

  // ########################################
  // decode and execute
  // ########################################

  always_comb begin
    case (op_q)
      OP_ARITH:  alu_res = func_q ? rs_val_q - rt_val_q : rs_val_q + rt_val_q;
      OP_CMPMUL: alu_res = func_q ? rs_val_q * rt_val_q :
                           ((rs_val_q < rt_val_q) ? word_t'(1) : word_t'(0));
      default:   alu_res = '0;
    endcase
  end

  // word address, doubled to bytes later
  assign mem_sum = rs_val_q + imm_q;

  always_ff @(posedge clk) begin
    if (state_q == ST_DECODE && imem.inst_valid) begin
      op_q     <= opcode_e'(imem.inst[15:13]);
      rt_q     <= imem.inst[8:5];
      rd_q     <= imem.inst[4:1];
      func_q   <= imem.inst[0];
      imm_q    <= imem.inst[4:0];
      tgt_q    <= imem.inst[11:0];
      rs_val_q <= regs[imem.inst[12:9]];
      rt_val_q <= regs[imem.inst[8:5]];
    end
    if (state_q == ST_EXE) begin
      res_q  <= alu_res;
      addr_q <= {mem_sum[`CPU_PTR_W-2:0], 1'b0};
    end
  end

  // register file, R-type into rd and loads into rt
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) begin
        regs[i] <= '0;
      end
    end else if (state_q == ST_WB && (op_q == OP_ARITH || op_q == OP_CMPMUL)) begin
      regs[rd_q] <= res_q;
    end else if (state_q == ST_LOAD && dmem.done) begin
      regs[rt_q] <= dmem.rdata;
    end
  end

  assign imem.fetch  = fetch_q;
  assign imem.pc     = pc_q;
  assign dmem.ld_req = (state_q == ST_LOAD);
  assign dmem.st_req = (state_q == ST_STORE);
  assign dmem.addr   = addr_q;
  assign dmem.wdata  = rt_val_q;

  // one low cycle per retired instruction
  assign io_stall = (state_q != ST_WB);

endmodule

/* src/cpu_top.sv */
/*
 * cpu top
 * core, instruction and data caches and the read arbiter,
 * exposed as a plain AXI-style master
 */
`timescale 1ns/1ps
`include "cpu_macros.svh"

module cpu_top (
  input  logic                       clk,
  input  logic                       rst_n,
  // read channel
  output logic [`CPU_AXI_ADDR_W-1:0] araddr,
  output logic                       arvalid,
  input  logic                       arready,
  input  cpu_pkg::word_t             rdata,
  input  logic                       rvalid,
  input  logic                       rlast,
  output logic                       rready,
  // write channel
  output logic [`CPU_AXI_ADDR_W-1:0] awaddr,
  output logic                       awvalid,
  input  logic                       awready,
  output cpu_pkg::word_t             wdata,
  output logic                       wvalid,
  output logic                       wlast,
  input  logic                       wready,
  input  logic                       bvalid,
  output logic                       bready,
  output logic                       io_stall
);

  imem_if    imem ();
  dmem_if    dmem ();
  rd_port_if inst_rd ();
  rd_port_if data_rd ();

  cpu_core u_core (
    .clk      (clk),
    .rst_n    (rst_n),
    .imem     (imem.core),
    .dmem     (dmem.core),
    .io_stall (io_stall)
  );

  inst_cache u_icache (
    .clk   (clk),
    .rst_n (rst_n),
    .core  (imem.cache),
    .bus   (inst_rd.requester)
  );

  data_cache u_dcache (
    .clk     (clk),
    .rst_n   (rst_n),
    .core    (dmem.cache),
    .bus     (data_rd.requester),
    .awaddr  (awaddr),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wvalid  (wvalid),
    .wlast   (wlast),
    .wready  (wready),
    .bvalid  (bvalid),
    .bready  (bready)
  );

  read_arbiter u_rd_arb (
    .clk       (clk),
    .rst_n     (rst_n),
    .inst_port (inst_rd.arbiter),
    .data_port (data_rd.arbiter),
    .araddr    (araddr),
    .arvalid   (arvalid),
    .arready   (arready),
    .rdata     (rdata),
    .rvalid    (rvalid),
    .rlast     (rlast),
    .rready    (rready)
  );

endmodule

/* verif/tb_cpu_top.sv */
/*
 * cpu top testbench
 * random program in a DRAM model with stalling AXI channels,
 * checked against an ISA reference model with window tracking
 */
`timescale 1ns/1ps

module tb_cpu_top;

  localparam int PROG_LEN   = 300;
  localparam int RETIRES    = 800;
  localparam int MAX_CYCLES = 400000;
  localparam int SEED       = 36;

  logic        clk;
  logic        rst_n;
  logic [31:0] araddr;
  logic        arvalid;
  logic        arready;
  logic [15:0] rdata;
  logic        rvalid;
  logic        rlast;
  logic        rready;
  logic [31:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [15:0] wdata;
  logic        wvalid;
  logic        wlast;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic        io_stall;

  // DRAM words and the reference copy
  logic [15:0]        dram [2048];
  logic [15:0]        ref_mem [2048];
  logic signed [15:0] ref_regs [16];
  logic [11:0]        ref_pc;
  logic               iwin_valid;
  logic [11:0]        iwin_base;
  logic               dwin_valid;
  logic [11:0]        dwin_base;

  logic [31:0] exp_ar [$];
  logic [31:0] exp_waddr [$];
  logic [15:0] exp_wdata [$];

  int unsigned retire_cnt;

  cpu_top u_dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .araddr   (araddr),
    .arvalid  (arvalid),
    .arready  (arready),
    .rdata    (rdata),
    .rvalid   (rvalid),
    .rlast    (rlast),
    .rready   (rready),
    .awaddr   (awaddr),
    .awvalid  (awvalid),
    .awready  (awready),
    .wdata    (wdata),
    .wvalid   (wvalid),
    .wlast    (wlast),
    .wready   (wready),
    .bvalid   (bvalid),
    .bready   (bready),
    .io_stall (io_stall)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic report_failure();
    $display("sim failed");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
      report_failure();
    end
  endtask

  task automatic check_true(bit cond, string what);
    assert (cond) else begin
      $display("Error at %0t: %s", $time, what);
      report_failure();
    end
  endtask

  // ########################################
  // reference model
  // ########################################

  function automatic bit window_hit(bit v, logic [11:0] base, logic [11:0] p);
    logic [11:0] off;
    off = p - base;
    return v && (p >= base) && (off < 12'd256);
  endfunction

  function automatic logic [11:0] window_start(logic [11:0] p);
    logic [11:0] s;
    s = (p > 12'd3840) ? 12'd3840 : p;
    return {s[11:1], 1'b0};
  endfunction

  function automatic bit ref_step(output logic [31:0] st_addr, output logic [15:0] st_data);
    logic [15:0]        inst;
    logic [2:0]         op;
    logic signed [15:0] a;
    logic signed [15:0] b;
    logic signed [15:0] imm;
    logic signed [15:0] sum;
    logic [11:0]        addr;
    logic [11:0]        next_pc;
    bit                 is_store;
    is_store = 1'b0;
    st_addr  = '0;
    st_data  = '0;
    if (!window_hit(iwin_valid, iwin_base, ref_pc)) begin
      iwin_valid = 1'b1;
      iwin_base  = window_start(ref_pc);
      exp_ar.push_back(32'h1000 + iwin_base);
    end
    inst    = ref_mem[ref_pc[11:1]];
    op      = inst[15:13];
    a       = ref_regs[inst[12:9]];
    b       = ref_regs[inst[8:5]];
    imm     = {{11{inst[4]}}, inst[4:0]};
    sum     = a + imm;
    addr    = {sum[10:0], 1'b0};
    next_pc = ref_pc + 12'd2;
    case (op)
      3'b000: ref_regs[inst[4:1]] = inst[0] ? a - b : a + b;
      3'b001: ref_regs[inst[4:1]] = inst[0] ? a * b : ((a < b) ? 16'sd1 : 16'sd0);
      3'b010: begin
        if (!window_hit(dwin_valid, dwin_base, addr)) begin
          dwin_valid = 1'b1;
          dwin_base  = window_start(addr);
          exp_ar.push_back(32'h1000 + dwin_base);
        end
        ref_regs[inst[8:5]] = ref_mem[addr[11:1]];
      end
      3'b011: begin
        is_store             = 1'b1;
        st_addr              = 32'h1000 + addr;
        st_data              = b;
        ref_mem[addr[11:1]] = b;
      end
      3'b100: if (a == b) next_pc = ref_pc + 12'd2 + {imm[10:0], 1'b0};
      3'b101: next_pc = inst[11:0];
      default: ;
    endcase
    ref_pc = next_pc;
    return is_store;
  endfunction

  // random program with stores and half of the loads in the top 32 bytes
  task automatic build_program();
    int unsigned r;
    logic [3:0]  rs;
    logic [3:0]  rt;
    logic [4:0]  imm;
    for (int w = 0; w < 2048; w++) begin
      dram[w] = 16'(w * 40503) ^ 16'h3c5a;
    end
    for (int i = 0; i < PROG_LEN - 1; i++) begin
      r  = $urandom % 100;
      rs = 4'($urandom);
      rt = 4'($urandom % 14 + 1);
      if (r < 40) begin
        dram[i] = {2'b00, 1'($urandom), rs, 4'($urandom), rt, 1'($urandom)};
      end else if (r < 60) begin
        imm = 5'($urandom);
        if ($urandom % 2 == 0) begin
          rs  = 4'd0;
          imm = {1'b1, 4'($urandom)};
        end
        dram[i] = {3'b010, rs, rt, imm};
      end else if (r < 80) begin
        dram[i] = {3'b011, 4'd0, 4'($urandom), 1'b1, 4'($urandom)};
      end else begin
        rt  = ($urandom % 3 == 0) ? rs : 4'($urandom);
        imm = 5'($urandom % 16);
        if (i + 1 + imm > PROG_LEN - 1) imm = '0;
        dram[i] = {3'b100, rs, rt, imm};
      end
    end
    // jump back to the start forces an instruction refill
    dram[PROG_LEN-1] = {3'b101, 1'b0, 12'd0};
  endtask

  // ########################################
  // DRAM model
  // ########################################

  logic        rd_busy;
  logic [10:0] rd_base;
  logic [6:0]  rd_idx;
  logic [31:0] wr_addr;
  logic        b_pend;
  logic        r_stalled;
  logic        b_stalled;

  always @(posedge clk) begin
    if (arvalid && arready) begin
      rd_busy = 1'b1;
      rd_base = 11'((araddr - 32'h1000) >> 1);
      rd_idx  = '0;
    end
    if (rvalid && rready) begin
      if (rlast) rd_busy = 1'b0;
      else rd_idx++;
    end
    if (awvalid && awready) wr_addr = awaddr;
    if (wvalid && wready) begin
      dram[11'((wr_addr - 32'h1000) >> 1)] = wdata;
      b_pend = 1'b1;
    end
    if (bvalid && bready) b_pend = 1'b0;
    r_stalled = rvalid && !rready;
    b_stalled = bvalid && !bready;
    #1;
    arready = !rd_busy && ($urandom % 4 != 0);
    if (rd_busy) begin
      if (!r_stalled) rvalid = ($urandom % 4 != 0);
      rdata = dram[rd_base + 11'(rd_idx)];
      rlast = (rd_idx == 7'd127);
    end else begin
      rvalid = 1'b0;
      rlast  = 1'b0;
    end
    awready = ($urandom % 3 != 0);
    wready  = ($urandom % 3 != 0);
    if (b_pend) begin
      if (!b_stalled) bvalid = ($urandom % 3 != 0);
    end else begin
      bvalid = 1'b0;
    end
  end

  // ########################################
  // compare process
  // ########################################

  logic        stall_prev;
  logic        ar_hold;
  logic [31:0] ar_addr_q;
  logic        aw_hold;
  logic [31:0] aw_addr_q;
  logic        w_hold;
  logic [15:0] w_data_q;
  logic        b_hold;
  logic        aw_seen;

  always @(posedge clk) begin
    if (rst_n) begin
      if (!io_stall) begin
        check_true(stall_prev, "io_stall low for more than one cycle");
        retire_cnt++;
      end
      stall_prev = io_stall;

      if (ar_hold) begin
        check_true(arvalid, "arvalid dropped before arready");
        check_value("araddr", araddr, ar_addr_q);
      end
      ar_hold   = arvalid && !arready;
      ar_addr_q = araddr;
      if (arvalid && arready) begin
        check_true(exp_ar.size() > 0, "read burst not predicted by the reference");
        check_value("araddr", araddr, exp_ar.pop_front());
      end
      if (rvalid) check_true(rready, "rready low during a read burst");

      if (aw_hold) begin
        check_true(awvalid, "awvalid dropped before awready");
        check_value("awaddr", awaddr, aw_addr_q);
      end
      aw_hold   = awvalid && !awready;
      aw_addr_q = awaddr;
      if (awvalid && awready) begin
        check_true(exp_waddr.size() > 0, "write not predicted by the reference");
        check_value("awaddr", awaddr, exp_waddr[0]);
        aw_seen = 1'b1;
      end

      check_value("wlast", 32'(wlast), 32'(wvalid));
      if (w_hold) begin
        check_true(wvalid, "wvalid dropped before wready");
        check_value("wdata", 32'(wdata), 32'(w_data_q));
      end
      if (wvalid) check_true(aw_seen, "wvalid before the write address");
      w_hold   = wvalid && !wready;
      w_data_q = wdata;
      if (wvalid && wready) begin
        check_value("wdata", 32'(wdata), 32'(exp_wdata.pop_front()));
        void'(exp_waddr.pop_front());
        aw_seen = 1'b0;
      end

      if (b_hold) check_true(bready, "bready dropped before bvalid");
      b_hold = bready && !bvalid;
    end
  end

  // ########################################
  // main sequence
  // ########################################

  initial begin
    logic [31:0] sa;
    logic [15:0] sd;
    int unsigned cycles;
    rst_n      = 1'b0;
    arready    = 1'b0;
    rdata      = '0;
    rvalid     = 1'b0;
    rlast      = 1'b0;
    awready    = 1'b0;
    wready     = 1'b0;
    bvalid     = 1'b0;
    rd_busy    = 1'b0;
    rd_base    = '0;
    rd_idx     = '0;
    wr_addr    = '0;
    b_pend     = 1'b0;
    stall_prev = 1'b1;
    ar_hold    = 1'b0;
    aw_hold    = 1'b0;
    w_hold     = 1'b0;
    b_hold     = 1'b0;
    aw_seen    = 1'b0;
    retire_cnt = 0;
    void'($urandom(SEED));

    build_program();
    ref_mem    = dram;
    ref_pc     = '0;
    iwin_valid = 1'b0;
    dwin_valid = 1'b0;
    iwin_base  = '0;
    dwin_base  = '0;
    for (int i = 0; i < 16; i++) ref_regs[i] = '0;
    for (int n = 0; n < RETIRES; n++) begin
      if (ref_step(sa, sd)) begin
        exp_waddr.push_back(sa);
        exp_wdata.push_back(sd);
      end
    end

    repeat (5) @(posedge clk);
    #1;
    check_true(io_stall && !arvalid && !rready && !awvalid && !wvalid && !bready,
               "outputs not idle during reset");
    rst_n = 1'b1;

    cycles = 0;
    while (retire_cnt < RETIRES) begin
      @(posedge clk);
      #2;
      cycles++;
      if (cycles > MAX_CYCLES) begin
        $display("Error: timeout after %0d retirements", retire_cnt);
        report_failure();
      end
    end

    check_true(exp_ar.size() == 0, "predicted read bursts never issued");
    check_true(exp_waddr.size() == 0, "predicted stores never written");
    $display("sim passed");
    $finish;
  end

endmodule

/* cpu_top.f */
+incdir+src
src/cpu_pkg.sv
src/cpu_ifs.sv
src/read_arbiter.sv
src/inst_cache.sv
src/data_cache.sv
src/cpu_core.sv
src/cpu_top.sv
verif/tb_cpu_top.sv

/* Makefile */
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert -Wno-fatal -Isrc
TOP       ?= tb_cpu_top
FILELIST  ?= cpu_top.f

OBJ_DIR := obj_dir
BIN     := $(OBJ_DIR)/V$(TOP)
SOURCES := $(wildcard src/*.sv src/*.svh verif/*.sv)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "sim passed"

clean:
	rm -rf $(OBJ_DIR)
